// File: hw/adc_acq_macros.svh
`ifndef ADC_ACQ_MACROS_SVH
`define ADC_ACQ_MACROS_SVH

//////////////////////////////
// sample format
//////////////////////////////

`define ADC_SAMPLE_W     12    // bits per adc sample, over-range bit not included

//////////////////////////////
// buffering
//////////////////////////////

`define BUF_ADDR_W       10    // circular buffer address, depth is 2**BUF_ADDR_W
`define TRIG_FIFO_DEPTH  4     // stored trigger addresses, power of two

//////////////////////////////
// readout
//////////////////////////////

`define BURST_PAIRS      4     // sample pairs per data word
`define CREDIT_MAX       8     // credits held after reset, also the ceiling
`define FILL_NUM_W       24    // fill counter width
`define NUM_BURSTS_W     8     // bursts per waveform

`endif

// File: hw/adc_acq_pkg.sv
`default_nettype none

`include "adc_acq_macros.svh"

package adc_acq_pkg;

    localparam int PAYLOAD_W  = 128;                      // payload of one output word
    localparam int PAIR_W     = 2 * (`ADC_SAMPLE_W + 1);  // two samples with over-range bits
    localparam int DATA_PAD_W = PAYLOAD_W - `BURST_PAIRS * PAIR_W;
    localparam int HDR_PAD_W  = PAYLOAD_W - 12 - `FILL_NUM_W - `BUF_ADDR_W - `NUM_BURSTS_W;

    // one sample, over-range in bit 0 like the packed adc bus
    typedef struct packed {
        logic [`ADC_SAMPLE_W-1:0] data;
        logic                     ovr;
    } adc_sample_t;

    typedef struct packed {
        adc_sample_t s1;    // second sample, upper 13 bits
        adc_sample_t s0;    // first sample, lower 13 bits
    } sample_pair_t;

    typedef logic [`BUF_ADDR_W-1:0] buf_addr_t;

    // quasi-static settings, held stable while a waveform is read out
    typedef struct packed {
        logic [11:0]              channel_tag;
        logic                     use_dummy;   // counter pattern instead of sample_in
        buf_addr_t                pre_trig;    // pairs kept ahead of the trigger
        logic [`NUM_BURSTS_W-1:0] num_bursts;  // at least 1
    } acq_cfg_t;

    typedef enum logic [3:0] {
        TAG_WFM_HDR = 4'h1,
        TAG_DATA    = 4'h2
    } word_tag_e;

    typedef struct packed {
        logic [HDR_PAD_W-1:0]     pad;
        logic [`NUM_BURSTS_W-1:0] num_bursts;
        buf_addr_t                start_addr;
        logic [`FILL_NUM_W-1:0]   fill_num;
        logic [11:0]              channel_tag;  // lowest bits of the header
    } wfm_hdr_t;

    typedef struct packed {
        logic [DATA_PAD_W-1:0]            pad;    // always zero
        sample_pair_t [`BURST_PAIRS-1:0]  pairs;  // pairs[0] is the oldest
    } wfm_data_t;

    typedef struct packed {
        word_tag_e             tag;
        logic [PAYLOAD_W-1:0]  payload;  // wfm_hdr_t or wfm_data_t
    } acq_word_t;

endpackage

`default_nettype wire

// File: hw/adc_acq_top.sv
`default_nettype none

`include "adc_acq_macros.svh"

module adc_acq_top import adc_acq_pkg::*; (
    input  wire logic                    adc_clk,
    input  wire logic                    rst,
    input  wire acq_cfg_t                cfg,
    input  wire sample_pair_t            sample_in,
    input  wire logic                    acq_enable,
    input  wire logic                    acq_trig,
    input  wire logic                    fill_num_load,
    input  wire logic [`FILL_NUM_W-1:0]  initial_fill_num,
    input  wire logic                    out_credit,
    output acq_word_t                    out_word,
    output logic                         out_valid,
    output logic                         acq_busy,
    output logic [`FILL_NUM_W-1:0]       fill_num
);

    logic          wr_en;        // capture -> buffer
    buf_addr_t     wr_addr;
    sample_pair_t  wr_data;
    logic          trig_push;    // capture -> trigger fifo
    buf_addr_t     trig_addr;
    logic          trig_pop;     // readout <-> trigger fifo
    buf_addr_t     trig_head;
    logic          trig_empty;
    buf_addr_t     rd_addr;      // readout <-> buffer
    sample_pair_t  rd_data;

    //////////////////////////////
    // capture side
    //////////////////////////////

    sample_capture u_capture (
        .adc_clk    (adc_clk),
        .rst        (rst),
        .acq_enable (acq_enable),
        .acq_trig   (acq_trig),
        .use_dummy  (cfg.use_dummy),
        .sample_in  (sample_in),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .trig_push  (trig_push),
        .trig_addr  (trig_addr)
    );

    circ_buf u_buf (
        .adc_clk (adc_clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    trig_addr_fifo u_trig_fifo (
        .adc_clk   (adc_clk),
        .rst       (rst),
        .push      (trig_push),
        .push_addr (trig_addr),
        .pop       (trig_pop),
        .head      (trig_head),
        .empty     (trig_empty)
    );

    //////////////////////////////
    // readout side
    //////////////////////////////

    wfm_readout u_readout (
        .adc_clk          (adc_clk),
        .rst              (rst),
        .cfg              (cfg),
        .trig_empty       (trig_empty),
        .trig_head        (trig_head),
        .rd_data          (rd_data),
        .fill_num_load    (fill_num_load),
        .initial_fill_num (initial_fill_num),
        .out_credit       (out_credit),
        .trig_pop         (trig_pop),
        .rd_addr          (rd_addr),
        .out_word         (out_word),
        .out_valid        (out_valid),
        .acq_busy         (acq_busy),
        .fill_num         (fill_num)
    );

endmodule

`default_nettype wire

// File: hw/circ_buf.sv
`default_nettype none

`include "adc_acq_macros.svh"

module circ_buf import adc_acq_pkg::*; (
    input  wire logic          adc_clk,
    input  wire logic          wr_en,
    input  wire buf_addr_t     wr_addr,
    input  wire sample_pair_t  wr_data,
    input  wire buf_addr_t     rd_addr,
    output sample_pair_t       rd_data     // valid one cycle after rd_addr
);

    localparam int DEPTH = 1 << `BUF_ADDR_W;

    //////////////////////////////
    // storage
    //////////////////////////////

    // one pair per entry, a single block ram
    sample_pair_t mem [DEPTH];

    // write port, capture side
    always_ff @(posedge adc_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read port, readout side
    // same-address collision returns the old entry
    always_ff @(posedge adc_clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: hw/sample_capture.sv
`default_nettype none

`include "adc_acq_macros.svh"

module sample_capture import adc_acq_pkg::*; (
    input  wire logic          adc_clk,
    input  wire logic          rst,
    input  wire logic          acq_enable,   // write the buffer while high
    input  wire logic          acq_trig,     // level, rising edge is the trigger
    input  wire logic          use_dummy,
    input  wire sample_pair_t  sample_in,
    output logic               wr_en,
    output buf_addr_t          wr_addr,
    output sample_pair_t       wr_data,
    output logic               trig_push,    // one cycle per accepted edge
    output buf_addr_t          trig_addr
);

    logic                      enable_q;     // enable level last cycle
    logic                      trig_q;       // trigger level last cycle
    buf_addr_t                 addr_q;       // address for the next enabled cycle
    logic [`ADC_SAMPLE_W-2:0]  dummy_q;      // n of the next dummy pair
    logic                      enable_rise;
    logic [`ADC_SAMPLE_W-2:0]  dummy_n;      // n used this cycle
    sample_pair_t              dummy_pair;

    //////////////////////////////
    // write side
    //////////////////////////////

    assign enable_rise = acq_enable && !enable_q;
    assign wr_addr     = enable_rise ? '0 : addr_q;   // restart at 0 on a new period
    assign dummy_n     = enable_rise ? '0 : dummy_q;

    always_comb begin
        dummy_pair         = '0;                  // over-range bits stay clear
        dummy_pair.s0.data = {dummy_n, 1'b0};     // 2n mod 4096
        dummy_pair.s1.data = {dummy_n, 1'b1};     // 2n+1 mod 4096
    end

    assign wr_en   = acq_enable;
    assign wr_data = use_dummy ? dummy_pair : sample_in;

    //////////////////////////////
    // trigger edge
    //////////////////////////////

    assign trig_push = acq_trig && !trig_q && acq_enable;
    assign trig_addr = wr_addr;                   // address written in the trigger cycle

    always_ff @(posedge adc_clk) begin
        if (rst) begin
            enable_q <= 1'b0;
            trig_q   <= 1'b0;
            addr_q   <= '0;
            dummy_q  <= '0;
        end else begin
            enable_q <= acq_enable;
            trig_q   <= acq_trig;
            if (acq_enable) begin
                addr_q  <= wr_addr + 1'b1;        // wraps at the buffer depth
                dummy_q <= dummy_n + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/trig_addr_fifo.sv
`default_nettype none

`include "adc_acq_macros.svh"

module trig_addr_fifo import adc_acq_pkg::*; #(
    parameter int DEPTH = `TRIG_FIFO_DEPTH    // power of two
) (
    input  wire logic       adc_clk,
    input  wire logic       rst,
    input  wire logic       push,
    input  wire buf_addr_t  push_addr,
    input  wire logic       pop,
    output buf_addr_t       head,              // oldest entry, valid while !empty
    output logic            empty
);

    localparam int PTR_W = $clog2(DEPTH);

    buf_addr_t         mem [DEPTH];
    logic [PTR_W:0]    wr_ptr;                 // extra msb tells full from empty
    logic [PTR_W:0]    rd_ptr;
    logic              full;
    logic              do_push;
    logic              do_pop;

    //////////////////////////////
    // flags
    //////////////////////////////

    assign empty   = (wr_ptr == rd_ptr);
    assign full    = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                     (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
    assign do_push = push && !full;            // trigger lost when full
    assign do_pop  = pop && !empty;

    // fall-through, head read straight from the array
    assign head = mem[rd_ptr[PTR_W-1:0]];

    always_ff @(posedge adc_clk) begin
        if (do_push) begin
            mem[wr_ptr[PTR_W-1:0]] <= push_addr;
        end
    end

    //////////////////////////////
    // pointers
    //////////////////////////////

    always_ff @(posedge adc_clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/wfm_readout.sv
`default_nettype none

`include "adc_acq_macros.svh"

module wfm_readout import adc_acq_pkg::*; (
    input  wire logic                    adc_clk,
    input  wire logic                    rst,
    input  wire acq_cfg_t                cfg,
    input  wire logic                    trig_empty,
    input  wire buf_addr_t               trig_head,
    input  wire sample_pair_t            rd_data,
    input  wire logic                    fill_num_load,
    input  wire logic [`FILL_NUM_W-1:0]  initial_fill_num,
    input  wire logic                    out_credit,      // one credit back per cycle
    output logic                         trig_pop,
    output buf_addr_t                    rd_addr,
    output acq_word_t                    out_word,
    output logic                         out_valid,
    output logic                         acq_busy,
    output logic [`FILL_NUM_W-1:0]       fill_num
);

    localparam int CREDIT_W   = $clog2(`CREDIT_MAX + 1);
    localparam int PAIR_CNT_W = $clog2(`BURST_PAIRS);

    typedef enum logic [1:0] {
        ST_IDLE,        // wait for a trigger address
        ST_HDR,         // header out once a credit is free
        ST_RD_BURST,    // credit, then BURST_PAIRS back-to-back reads
        ST_EMIT         // last pair lands, data word out
    } state_e;

    state_e                          state;
    buf_addr_t                       rd_addr_q;
    logic [PAIR_CNT_W-1:0]           pair_cnt;      // reads issued in this burst
    logic [`NUM_BURSTS_W-1:0]        bursts_left;
    logic [CREDIT_W-1:0]             credit_cnt;
    logic [`FILL_NUM_W-1:0]          fill_q;
    sample_pair_t [`BURST_PAIRS-2:0] hold_q;        // pairs read so far, [0] oldest
    logic                            last_q;        // final word of the waveform is out
    logic                            credit_ok;
    logic                            burst_start;
    logic                            read_issue;
    logic                            shift_en;
    logic                            credit_take;
    logic                            last_word;
    wfm_hdr_t                        hdr;
    wfm_data_t                       data_word;

    //////////////////////////////
    // control decodes
    //////////////////////////////

    assign credit_ok   = (credit_cnt != '0);
    assign burst_start = (state == ST_RD_BURST) && (pair_cnt == '0) && credit_ok;
    assign shift_en    = (state == ST_RD_BURST) && (pair_cnt != '0);  // previous read is back
    assign read_issue  = burst_start || shift_en;
    // a word reserves its credit when committed, so one word is in flight at most
    assign credit_take = ((state == ST_HDR) && credit_ok) || burst_start;
    assign last_word   = (state == ST_EMIT) && (bursts_left == `NUM_BURSTS_W'(1));

    assign trig_pop = (state == ST_IDLE) && !trig_empty;
    assign rd_addr  = rd_addr_q;
    assign fill_num = fill_q;
    assign acq_busy = (state != ST_IDLE) || last_q;      // covers the final word

    always_comb begin
        hdr             = '0;
        hdr.channel_tag = cfg.channel_tag;
        hdr.fill_num    = fill_q;
        hdr.start_addr  = rd_addr_q;        // no read issued yet in ST_HDR
        hdr.num_bursts  = cfg.num_bursts;
        data_word                        = '0;
        data_word.pairs[`BURST_PAIRS-1]   = rd_data;   // newest pair, straight from the ram
        data_word.pairs[`BURST_PAIRS-2:0] = hold_q;
    end

    //////////////////////////////
    // state machine
    //////////////////////////////

    always_ff @(posedge adc_clk) begin
        if (rst) begin
            state       <= ST_IDLE;
            pair_cnt    <= '0;
            bursts_left <= '0;
            out_valid   <= 1'b0;
            last_q      <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            last_q    <= last_word;
            case (state)
                ST_IDLE: begin
                    if (!trig_empty) begin
                        bursts_left <= cfg.num_bursts;
                        state       <= ST_HDR;
                    end
                end
                ST_HDR: begin
                    if (credit_ok) begin
                        out_valid <= 1'b1;
                        state     <= ST_RD_BURST;
                    end
                end
                ST_RD_BURST: begin
                    if (read_issue) begin
                        pair_cnt <= pair_cnt + 1'b1;   // wraps to 0 for the next burst
                        if (pair_cnt == PAIR_CNT_W'(`BURST_PAIRS - 1)) begin
                            state <= ST_EMIT;
                        end
                    end
                end
                ST_EMIT: begin
                    out_valid   <= 1'b1;
                    bursts_left <= bursts_left - 1'b1;
                    state       <= last_word ? ST_IDLE : ST_RD_BURST;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    //////////////////////////////
    // address, burst, output word
    //////////////////////////////

    always_ff @(posedge adc_clk) begin
        if (trig_pop) begin
            rd_addr_q <= trig_head - cfg.pre_trig;     // modulo buffer depth
        end else if (read_issue) begin
            rd_addr_q <= rd_addr_q + 1'b1;
        end
        if (shift_en) begin
            hold_q <= {rd_data, hold_q[`BURST_PAIRS-2:1]};
        end
        if ((state == ST_HDR) && credit_ok) begin
            out_word.tag     <= TAG_WFM_HDR;
            out_word.payload <= hdr;
        end else if (state == ST_EMIT) begin
            out_word.tag     <= TAG_DATA;
            out_word.payload <= data_word;
        end
    end

    //////////////////////////////
    // credits and fill number
    //////////////////////////////

    always_ff @(posedge adc_clk) begin
        if (rst) begin
            credit_cnt <= CREDIT_W'(`CREDIT_MAX);
            fill_q     <= '0;
        end else begin
            case ({credit_take, out_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;       // none, or spend and return
            endcase
            if (fill_num_load) begin
                fill_q <= initial_fill_num;
            end else if (last_word) begin
                fill_q <= fill_q + 1'b1;                 // next waveform's number
            end
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the acquisition testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module adc_acq_tb -f verilog.f -o adc_acq_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/adc_acq_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
echo "pass message not found"
exit 1

// File: verif/adc_acq_checker.sv
`default_nettype none

`include "adc_acq_macros.svh"

module adc_acq_checker (
    input wire logic adc_clk,
    input wire logic rst,
    input wire logic out_valid,
    input wire logic acq_busy,
    input wire logic out_credit
);

    timeunit 1ns;
    timeprecision 1ps;

    int credits;                                   // mirror seen from the ports only

    //////////////////////////////
    // credit mirror
    //////////////////////////////

    always_ff @(posedge adc_clk) begin
        if (rst) begin
            credits <= `CREDIT_MAX;
        end else begin
            credits <= credits - int'(out_valid) + int'(out_credit);
        end
    end

    // first cycle out of reset
    a_reset_quiet: assert property (@(posedge adc_clk)
        $past(rst) && !rst |-> !out_valid && !acq_busy)
        else $error("out_valid or acq_busy high right after reset");

    a_credit_avail: assert property (@(posedge adc_clk) disable iff (rst)
        out_valid |-> credits != 0)
        else $error("word sent with zero credits");

    a_busy_cover: assert property (@(posedge adc_clk) disable iff (rst)
        out_valid |-> acq_busy)
        else $error("out_valid without acq_busy");

endmodule

bind adc_acq_top adc_acq_checker u_checker (.*);

`default_nettype wire

// File: verif/adc_acq_tb.sv
`default_nettype none

`include "adc_acq_macros.svh"

module adc_acq_tb import adc_acq_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DEPTH   = 1 << `BUF_ADDR_W;
    localparam int TIMEOUT = 5000;                 // cycles per wait loop

    logic                     adc_clk = 1'b0;
    logic                     rst;
    acq_cfg_t                 cfg;
    sample_pair_t             sample_in;
    logic                     acq_enable;
    logic                     acq_trig;
    logic                     fill_num_load;
    logic [`FILL_NUM_W-1:0]   initial_fill_num;
    logic                     out_credit = 1'b0;   // driven only by the credit process
    acq_word_t                out_word;
    logic                     out_valid;
    logic                     acq_busy;
    logic [`FILL_NUM_W-1:0]   fill_num;

    integer                   seed = 32'hc0e8_22b1;
    integer                   credit_seed;         // own stream, independent of stimulus
    int                       errors;
    int                       timeouts;
    sample_pair_t             ref_buf [DEPTH];     // mirror of the circular buffer
    bit                       ref_known [DEPTH];   // entry written since start
    buf_addr_t                wr_addr_m;
    int                       dummy_m;
    logic                     prev_en;
    logic                     prev_trig;
    buf_addr_t                exp_trig [$];        // trigger addresses not yet read out
    int                       word_idx;            // 0 is the header
    logic [`FILL_NUM_W-1:0]   exp_fill;
    int                       tb_credits;          // credits the DUT may still spend
    int                       pending;             // words received, credit not returned
    bit                       slow_credit;

    always #5 adc_clk = ~adc_clk;

    adc_acq_top u_adc_acq_top (.*);

    //////////////////////////////
    // reference model
    //////////////////////////////

    function automatic sample_pair_t dummy_pair(int n);
        sample_pair_t d;
        d         = '0;
        d.s0.data = `ADC_SAMPLE_W'((2 * n) % 4096);      // 2n
        d.s1.data = `ADC_SAMPLE_W'((2 * n + 1) % 4096);  // 2n+1
        return d;
    endfunction

    function automatic buf_addr_t pair_addr(buf_addr_t trig, int widx, int j);
        buf_addr_t start;
        start = trig - cfg.pre_trig;                         // wraps mod depth
        return start + buf_addr_t'(4 * (widx - 1) + j);
    endfunction

    // header for widx 0, data word widx-1 otherwise
    function automatic acq_word_t expected_word(buf_addr_t trig, int widx,
                                                logic [`FILL_NUM_W-1:0] fill);
        wfm_hdr_t  h;
        wfm_data_t d;
        acq_word_t w;
        if (widx == 0) begin
            h             = '0;
            h.channel_tag = cfg.channel_tag;
            h.fill_num    = fill;
            h.start_addr  = trig - cfg.pre_trig;
            h.num_bursts  = cfg.num_bursts;
            w.tag         = TAG_WFM_HDR;
            w.payload     = h;
        end else begin
            d = '0;
            for (int j = 0; j < `BURST_PAIRS; j++) begin
                d.pairs[j] = ref_buf[pair_addr(trig, widx, j)];   // oldest low
            end
            w.tag     = TAG_DATA;
            w.payload = d;
        end
        return w;
    endfunction

    // pairs never written hold no defined value
    function automatic logic [PAYLOAD_W-1:0] known_mask(buf_addr_t trig, int widx);
        logic [PAYLOAD_W-1:0] m;
        m = '1;
        if (widx != 0) begin
            for (int j = 0; j < `BURST_PAIRS; j++) begin
                if (!ref_known[pair_addr(trig, widx, j)]) m[PAIR_W*j +: PAIR_W] = '0;
            end
        end
        return m;
    endfunction

    //////////////////////////////
    // checks and end of run
    //////////////////////////////

    task automatic check_word(acq_word_t got, acq_word_t exp, logic [PAYLOAD_W-1:0] mask);
        if (got.tag !== exp.tag || (got.payload & mask) !== (exp.payload & mask)) begin
            errors++;
            $display("CHECK FAILED at %0t ns: word %0d tag %0h payload %h, expected %0h %h",
                     $time, word_idx, got.tag, got.payload & mask, exp.tag,
                     exp.payload & mask);
        end
    endtask

    task automatic check_fill(logic [`FILL_NUM_W-1:0] got, logic [`FILL_NUM_W-1:0] exp,
                              string what);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic end_run();
        $display("run complete: %0d check failures, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////

    task automatic drive_cycle(logic en, logic trig);
        logic [31:0]  r;
        sample_pair_t p;
        r = $random(seed);
        p = r[PAIR_W-1:0];
        @(posedge adc_clk);
        acq_enable <= en;
        acq_trig   <= trig;
        sample_in  <= p;
        if (en) begin
            if (!prev_en) begin                 // new period restarts at 0
                wr_addr_m = '0;
                dummy_m   = 0;
            end
            if (trig && !prev_trig) exp_trig.push_back(wr_addr_m);
            ref_buf[wr_addr_m]   = cfg.use_dummy ? dummy_pair(dummy_m) : p;
            ref_known[wr_addr_m] = 1'b1;
            wr_addr_m++;
            dummy_m++;
        end
        prev_en   = en;
        prev_trig = trig;
    endtask

    function automatic logic trig_level(int i, int t);
        return (t >= 0) && (i == t || i == t + 1);   // two cycles high
    endfunction

    task automatic run_period(int len, int t0, int t1, int t2);
        for (int i = 0; i < len; i++) begin
            drive_cycle(1'b1, trig_level(i, t0) | trig_level(i, t1) | trig_level(i, t2));
        end
        repeat (4) drive_cycle(1'b0, 1'b0);
    endtask

    task automatic set_cfg(logic [11:0] tag, logic dummy, int pre, int bursts);
        acq_cfg_t c;
        c.channel_tag = tag;
        c.use_dummy   = dummy;
        c.pre_trig    = buf_addr_t'(pre);
        c.num_bursts  = `NUM_BURSTS_W'(bursts);
        @(posedge adc_clk);
        cfg <= c;
    endtask

    task automatic load_fill(logic [`FILL_NUM_W-1:0] v);
        @(posedge adc_clk);
        fill_num_load    <= 1'b1;
        initial_fill_num <= v;
        @(posedge adc_clk);
        fill_num_load    <= 1'b0;
        exp_fill          = v;
    endtask

    // all words out, DUT idle and every credit back
    task automatic wait_idle(string what);
        int n;
        n = 0;
        @(negedge adc_clk);
        while ((exp_trig.size() != 0 || acq_busy || tb_credits != `CREDIT_MAX) &&
               n < TIMEOUT) begin
            @(negedge adc_clk);
            n++;
        end
        if (n >= TIMEOUT) begin
            timeouts++;
            $display("timeout at %0t ns: %s did not finish in %0d cycles", $time, what, n);
        end
    endtask

    //////////////////////////////
    // credit return and compare
    //////////////////////////////

    always @(posedge adc_clk) begin
        if (rst) begin
            out_credit <= 1'b0;
            pending     = 0;
        end else begin
            if (pending > 0 && (!slow_credit || ($random(credit_seed) & 15) == 0)) begin
                out_credit <= 1'b1;
                pending--;
            end else begin
                out_credit <= 1'b0;
            end
            if (out_valid) pending++;              // word seen before this edge
        end
    end

    always @(negedge adc_clk) begin : compare_words
        wfm_hdr_t  got_hdr;
        acq_word_t exp_w;
        if (!rst) begin
            if (out_valid) begin
                if (tb_credits == 0) begin
                    errors++;
                    $display("error at %0t ns: word sent with no credit left", $time);
                end
                if (exp_trig.size() == 0) begin
                    errors++;
                    $display("error at %0t ns: word sent with no trigger pending", $time);
                end else begin
                    exp_w = expected_word(exp_trig[0], word_idx, exp_fill);
                    check_word(out_word, exp_w, known_mask(exp_trig[0], word_idx));
                    if (word_idx == 0) begin
                        got_hdr = out_word.payload;
                        check_fill(got_hdr.fill_num, exp_fill, "header fill number");
                    end
                    if (word_idx == int'(cfg.num_bursts)) begin
                        void'(exp_trig.pop_front());
                        word_idx = 0;
                        exp_fill++;                    // advances after the last word
                    end else begin
                        word_idx++;
                    end
                end
            end
            tb_credits = tb_credits - int'(out_valid) + int'(out_credit);
        end
    end

    //////////////////////////////
    // tests
    //////////////////////////////

    task automatic test_single();
        set_cfg(12'h5a1, 1'b0, 0, 6);
        run_period(1023, 500, -1, -1);            // fills 0..1022 for the wrap test
        wait_idle("random-data waveform");
    endtask

    task automatic test_wrap();
        set_cfg(12'h2c7, 1'b0, 17, 4);            // start 3-17 = 1010
        run_period(100, 3, -1, -1);
        wait_idle("wrapped waveform");
    endtask

    task automatic test_dummy();
        set_cfg(12'h0d3, 1'b1, 5, 5);
        run_period(300, 100, -1, -1);
        wait_idle("dummy-source waveform");
    endtask

    task automatic test_multi();
        load_fill(24'h00_1234);
        set_cfg(12'h777, 1'b0, 8, 3);
        run_period(600, 100, 250, 400);
        wait_idle("three-trigger readout");
        if (timeouts == 0) check_fill(fill_num, 24'h00_1237, "fill number after three waveforms");
    endtask

    task automatic test_credits();
        slow_credit = 1'b1;                       // credits trickle back
        set_cfg(12'h9e0, 1'b0, 30, 10);
        run_period(700, 200, 300, -1);
        wait_idle("slow-credit readout");
    endtask

    initial begin
        errors      = 0;
        timeouts    = 0;
        tb_credits  = `CREDIT_MAX;
        word_idx    = 0;
        exp_fill    = '0;
        prev_en     = 1'b0;
        prev_trig   = 1'b0;
        wr_addr_m   = '0;
        dummy_m     = 0;
        slow_credit = 1'b0;
        credit_seed = seed ^ 32'h5a5a_5a5a;
        for (int a = 0; a < DEPTH; a++) ref_known[a] = 1'b0;
        rst              = 1'b1;
        cfg              = '0;
        cfg.num_bursts   = `NUM_BURSTS_W'(1);
        sample_in        = '0;
        acq_enable       = 1'b0;
        acq_trig         = 1'b0;
        fill_num_load    = 1'b0;
        initial_fill_num = '0;
        repeat (3) @(posedge adc_clk);
        rst <= 1'b0;
        if (timeouts == 0) test_single();
        if (timeouts == 0) test_wrap();
        if (timeouts == 0) test_dummy();
        if (timeouts == 0) test_multi();
        if (timeouts == 0) test_credits();
        end_run();
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+hw
hw/adc_acq_pkg.sv
hw/sample_capture.sv
hw/circ_buf.sv
hw/trig_addr_fifo.sv
hw/wfm_readout.sv
hw/adc_acq_top.sv
verif/adc_acq_checker.sv
verif/adc_acq_tb.sv
